//--- ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// RV32I major opcodes
`define OP_R        7'b0110011
`define OP_I        7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_SYSTEM   7'b1110011

// ALU operations
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_OR      4'd3
`define ALU_XOR     4'd4
`define ALU_SLT     4'd5
`define ALU_SLTU    4'd6
`define ALU_SLL     4'd7
`define ALU_SRL     4'd8
`define ALU_SRA     4'd9
`define ALU_PASS_B  4'd10

// Datapath selectors
`define A_REG       1'b0
`define A_PC        1'b1
`define B_REG       1'b0
`define B_IMM       1'b1
`define REDIR_ALU   1'b0
`define REDIR_PC4   1'b1
`define CSR_RD1     1'b0
`define CSR_IMM     1'b1

// Store sizes, NONE for anything that is not a store
`define SIZE_B      2'd0
`define SIZE_H      2'd1
`define SIZE_W      2'd2
`define SIZE_NONE   2'd3

`define NOP         32'h00000013
`define CSR_TOHOST  12'h51e

// Top address nibble of the data memory
`define DMEM_REGION 4'h1
`define DMEM_WORDS  4096

`endif

//--- ex_pkg.sv
`default_nettype none

package ex_pkg;

    // Register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Immediate layout, also carries the CSR number
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } rv_inst_u;

endpackage

`default_nettype wire

//--- ex_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface ex_ctrl_if;

    logic [3:0] alu_op;
    logic       a_sel;
    logic       b_sel;
    logic       redirect_sel;
    logic [1:0] store_size;
    logic       dmem_en;
    logic       csr_en;
    logic       csr_sel;

    modport ctrl (
        output alu_op, a_sel, b_sel, redirect_sel,
        output store_size, dmem_en, csr_en, csr_sel
    );

    modport alu (input alu_op, a_sel, b_sel, redirect_sel);

    modport mem (input store_size, dmem_en);

    modport csr (input csr_en, csr_sel);

endinterface

`default_nettype wire

//--- ex_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_defines.svh"

module ex_control (
    input wire ex_pkg::rv_inst_u inst,
    input wire [31:0] pc,
    input wire [31:0] rd1,
    input wire [31:0] rd2,
    input wire [31:0] alu_res,
    input wire target_taken,
    input wire squash,
    output logic br_taken,
    output logic flush,
    ex_ctrl_if.ctrl ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       is_mem;
    logic       is_csrw;
    logic       in_region;
    logic       eq;
    logic       lt;
    logic       ltu;
    logic       cond;

    assign opcode = inst.r_fmt.opcode;
    assign funct3 = inst.r_fmt.funct3;
    // Instruction bit 30 picks sub and sra
    assign alt = inst.r_fmt.funct7[5];

    assign is_branch = opcode == `OP_BRANCH;
    assign is_jal = opcode == `OP_JAL;
    assign is_jalr = opcode == `OP_JALR;
    assign is_mem = (opcode == `OP_LOAD) || (opcode == `OP_STORE);
    // csrrw and csrrwi share funct3[1:0]
    assign is_csrw = (opcode == `OP_SYSTEM) && (funct3[1:0] == 2'b01)
                     && (inst.i_fmt.imm12 == `CSR_TOHOST);
    assign in_region = alu_res[31:28] == `DMEM_REGION;

    assign eq = rd1 == rd2;
    assign lt = $signed(rd1) < $signed(rd2);
    assign ltu = rd1 < rd2;

    always_comb begin
        case (funct3)
            3'b000: cond = eq;
            3'b001: cond = !eq;
            3'b100: cond = lt;
            3'b101: cond = !lt;
            3'b110: cond = ltu;
            3'b111: cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    assign br_taken = !squash && (is_jal || is_jalr || (is_branch && cond));
    // JAL already redirected in decode
    assign flush = !squash && (is_jalr || (is_branch && (cond != target_taken)));

    always_comb begin
        ctrl.alu_op = `ALU_ADD;
        ctrl.a_sel = `A_REG;
        ctrl.b_sel = `B_IMM;
        ctrl.store_size = `SIZE_NONE;
        case (opcode)
            `OP_R, `OP_I: begin
                if (opcode == `OP_R) begin
                    ctrl.b_sel = `B_REG;
                end
                case (funct3)
                    3'b000: ctrl.alu_op = (opcode == `OP_R && alt) ? `ALU_SUB : `ALU_ADD;
                    3'b001: ctrl.alu_op = `ALU_SLL;
                    3'b010: ctrl.alu_op = `ALU_SLT;
                    3'b011: ctrl.alu_op = `ALU_SLTU;
                    3'b100: ctrl.alu_op = `ALU_XOR;
                    3'b101: ctrl.alu_op = alt ? `ALU_SRA : `ALU_SRL;
                    3'b110: ctrl.alu_op = `ALU_OR;
                    default: ctrl.alu_op = `ALU_AND;
                endcase
            end
            `OP_BRANCH, `OP_JAL, `OP_AUIPC: ctrl.a_sel = `A_PC;
            `OP_LUI: ctrl.alu_op = `ALU_PASS_B;
            `OP_STORE: begin
                case (funct3[1:0])
                    2'b00: ctrl.store_size = `SIZE_B;
                    2'b01: ctrl.store_size = `SIZE_H;
                    default: ctrl.store_size = `SIZE_W;
                endcase
            end
            default: ctrl.alu_op = `ALU_ADD;
        endcase
    end

    assign ctrl.redirect_sel = br_taken ? `REDIR_ALU : `REDIR_PC4;
    assign ctrl.dmem_en = !squash && is_mem && in_region;
    assign ctrl.csr_en = !squash && is_csrw;
    assign ctrl.csr_sel = funct3[2] ? `CSR_IMM : `CSR_RD1;

    // Redirects only leave from aligned pcs
    always_comb begin
        if (flush) begin
            assert (pc[1:0] == 2'b00) else $error("redirect from misaligned pc %h", pc);
        end
    end

endmodule

`default_nettype wire

//--- alu_path.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_defines.svh"

module alu_path (
    input wire [31:0] pc,
    input wire [31:0] rd1,
    input wire [31:0] rd2,
    input wire [31:0] imm,
    ex_ctrl_if.alu ctrl,
    output logic [31:0] alu_res,
    output logic [31:0] pc4,
    output logic [31:0] redirect
);

    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  shamt;

    assign a = (ctrl.a_sel == `A_PC) ? pc : rd1;
    assign b = (ctrl.b_sel == `B_IMM) ? imm : rd2;
    assign shamt = b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            `ALU_ADD: alu_res = a + b;
            `ALU_SUB: alu_res = a - b;
            `ALU_AND: alu_res = a & b;
            `ALU_OR: alu_res = a | b;
            `ALU_XOR: alu_res = a ^ b;
            `ALU_SLT: alu_res = {31'b0, $signed(a) < $signed(b)};
            `ALU_SLTU: alu_res = {31'b0, a < b};
            `ALU_SLL: alu_res = a << shamt;
            `ALU_SRL: alu_res = a >> shamt;
            `ALU_SRA: alu_res = $signed(a) >>> shamt;
            `ALU_PASS_B: alu_res = b;
            default: alu_res = a + b;
        endcase
    end

    assign pc4 = pc + 32'd4;

    // Fall through unless the instruction was taken
    assign redirect = (ctrl.redirect_sel == `REDIR_ALU) ? alu_res : pc4;

endmodule

`default_nettype wire

//--- data_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_defines.svh"

module data_mem (
    input wire clk,
    input wire [31:0] addr,
    input wire [31:0] store_data,
    ex_ctrl_if.mem ctrl,
    output logic [31:0] din,
    output logic [3:0] we,
    output logic [31:0] dout
);

    localparam int AW = $clog2(`DMEM_WORDS);

    logic [31:0]   mem [0:`DMEM_WORDS-1];
    logic [AW-1:0] word_addr;
    logic [1:0]    offset;

    assign offset = addr[1:0];
    assign word_addr = addr[AW+1:2];

    // Line the store data up with its byte lane
    assign din = store_data << {offset, 3'b000};

    always_comb begin
        case (ctrl.store_size)
            `SIZE_B: we = 4'b0001 << offset;
            `SIZE_H: we = 4'b0011 << offset;
            `SIZE_W: we = 4'b1111;
            default: we = 4'b0000;
        endcase
        if (!ctrl.dmem_en) begin
            we = 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.dmem_en) begin
            dout <= mem[word_addr];
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[word_addr][8*i +: 8] <= din[8*i +: 8];
                end
            end
        end
    end

    assert property (@(posedge clk)
        (ctrl.dmem_en && ctrl.store_size == `SIZE_W) |-> addr[1:0] == 2'b00)
        else $error("misaligned word store to %h", addr);

endmodule

`default_nettype wire

//--- csr_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_defines.svh"

module csr_unit (
    input wire clk,
    input wire rst,
    input wire [31:0] rd1,
    input wire [31:0] imm,
    ex_ctrl_if.csr ctrl,
    output logic [31:0] tohost
);

    logic [31:0] csr_wdata;

    // csrrwi carries a 5-bit unsigned immediate
    assign csr_wdata = (ctrl.csr_sel == `CSR_IMM) ? {27'b0, imm[4:0]} : rd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            tohost <= '0;
        end else if (ctrl.csr_en) begin
            tohost <= csr_wdata;
        end
    end

endmodule

`default_nettype wire

//--- ex_wb_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_defines.svh"

module ex_wb_regs (
    input wire clk,
    input wire rst,
    input wire [31:0] inst,
    input wire [31:0] alu_res,
    input wire [31:0] pc4,
    input wire [31:0] redirect,
    input wire flush,
    output logic [31:0] wb_inst,
    output logic [31:0] wb_alu,
    output logic [31:0] wb_pc4,
    output logic [31:0] wb_redirect,
    output logic wb_flush
);

    always_ff @(posedge clk) begin
        wb_alu <= alu_res;
        wb_pc4 <= pc4;
        wb_redirect <= redirect;
    end

    // Wrong-path slot turns into a NOP
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_inst <= `NOP;
            wb_flush <= 1'b0;
        end else begin
            wb_inst <= wb_flush ? `NOP : inst;
            wb_flush <= flush;
        end
    end

    assert property (@(posedge clk) disable iff (rst) wb_flush |=> !wb_flush)
        else $error("back-to-back flush");

endmodule

`default_nettype wire

//--- ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
    input wire clk,
    input wire rst,

    input wire [31:0] ex_pc,
    input wire [31:0] ex_inst,
    input wire [31:0] ex_rd1,
    input wire [31:0] ex_rd2,
    input wire [31:0] ex_imm,
    input wire ex_target_taken,

    output wire [31:0] ex_addr,
    output wire [31:0] ex_din,
    output wire [3:0] ex_we,
    output wire ex_br_taken,
    output wire ex_flush,

    output wire [31:0] wb_inst,
    output wire [31:0] wb_alu,
    output wire [31:0] wb_pc4,
    output wire [31:0] wb_redirect,
    output wire wb_flush,
    output wire [31:0] wb_dmem_dout,
    output wire [31:0] tohost
);

    wire [31:0] pc4;
    wire [31:0] redirect;

    ex_ctrl_if ctrl_if ();

    // wb_flush squashes whatever sits in execute
    ex_control control (
        .inst(ex_inst),
        .pc(ex_pc),
        .rd1(ex_rd1),
        .rd2(ex_rd2),
        .alu_res(ex_addr),
        .target_taken(ex_target_taken),
        .squash(wb_flush),
        .br_taken(ex_br_taken),
        .flush(ex_flush),
        .ctrl(ctrl_if.ctrl)
    );

    alu_path alu (
        .pc(ex_pc),
        .rd1(ex_rd1),
        .rd2(ex_rd2),
        .imm(ex_imm),
        .ctrl(ctrl_if.alu),
        .alu_res(ex_addr),
        .pc4(pc4),
        .redirect(redirect)
    );

    data_mem dmem (
        .clk(clk),
        .addr(ex_addr),
        .store_data(ex_rd2),
        .ctrl(ctrl_if.mem),
        .din(ex_din),
        .we(ex_we),
        .dout(wb_dmem_dout)
    );

    csr_unit csr (
        .clk(clk),
        .rst(rst),
        .rd1(ex_rd1),
        .imm(ex_imm),
        .ctrl(ctrl_if.csr),
        .tohost(tohost)
    );

    ex_wb_regs wb_regs (
        .clk(clk),
        .rst(rst),
        .inst(ex_inst),
        .alu_res(ex_addr),
        .pc4(pc4),
        .redirect(redirect),
        .flush(ex_flush),
        .wb_inst(wb_inst),
        .wb_alu(wb_alu),
        .wb_pc4(wb_pc4),
        .wb_redirect(wb_redirect),
        .wb_flush(wb_flush)
    );

endmodule

`default_nettype wire

//--- tb_ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_defines.svh"

module tb_ex_stage;

    import ex_pkg::*;

    logic clk;
    logic rst;
    logic [31:0] ex_pc;
    logic [31:0] ex_inst;
    logic [31:0] ex_rd1;
    logic [31:0] ex_rd2;
    logic [31:0] ex_imm;
    logic ex_target_taken;
    wire [31:0] ex_addr;
    wire [31:0] ex_din;
    wire [3:0] ex_we;
    wire ex_br_taken;
    wire ex_flush;
    wire [31:0] wb_inst;
    wire [31:0] wb_alu;
    wire [31:0] wb_pc4;
    wire [31:0] wb_redirect;
    wire wb_flush;
    wire [31:0] wb_dmem_dout;
    wire [31:0] tohost;

    // Expected values for the instruction in execute (cur) and in writeback (prev)
    logic cur_valid = 1'b0;
    logic [31:0] cur_addr, cur_din, cur_pc4, cur_redirect;
    logic [3:0] cur_we;
    logic cur_taken, cur_dout_valid = 1'b0;
    logic cur_flush = 1'b0;
    logic [31:0] cur_winst = `NOP;
    logic [31:0] cur_tohost = '0;
    logic [31:0] cur_dout;
    logic prev_valid = 1'b0;
    logic prev_dout_valid = 1'b0;
    logic prev_flush = 1'b0;
    logic started = 1'b0;
    logic [31:0] prev_alu, prev_pc4, prev_redirect, prev_dout;
    logic [31:0] prev_winst = `NOP;
    logic [31:0] prev_tohost = '0;
    logic [31:0] model_tohost = '0;
    logic [31:0] shadow [0:`DMEM_WORDS-1];
    logic [31:0] lfsr = 32'h81f7d6e6;
    logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    ex_stage ex_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp, act);
        $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic timeout_abort(input string what);
        $display("Timed out waiting for %s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Signed, even offset within 4 KiB either way
    function automatic logic [31:0] branch_offset();
        logic [31:0] r;
        r = rand_bits(12);
        return {{20{r[11]}}, r[10:0], 1'b0};
    endfunction

    function automatic logic [31:0] alu_ref(input [2:0] f3, input alt, input [31:0] a, b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input [2:0] f3, input [31:0] a, b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic rv_inst_u make_inst(input [6:0] f7, input [2:0] f3, input [6:0] op);
        rv_inst_u u;
        u.r_fmt = '{f7, 5'd2, 5'd1, f3, 5'd3, op};
        return u;
    endfunction

    function automatic rv_inst_u make_csr(input [11:0] csr, input [2:0] f3);
        rv_inst_u u;
        u.i_fmt = '{csr, 5'd1, f3, 5'd0, `OP_SYSTEM};
        return u;
    endfunction

    // Drives one instruction and works out what the stage must answer
    task automatic issue(input rv_inst_u inst, input [31:0] pc, rd1, rd2, imm, input pred);
        logic squash, alt, cond, taken, en, is_ld, is_st;
        logic [6:0] op;
        logic [2:0] f3;
        logic [31:0] a, b, addr, din;
        logic [3:0] we;
        logic [11:0] w;
        @(posedge clk);
        squash = cur_flush;
        op = inst.r_fmt.opcode;
        f3 = inst.r_fmt.funct3;
        alt = inst.r_fmt.funct7[5] && (f3 == 3'd5 || (op == `OP_R && f3 == 3'd0));
        a = (op == `OP_BRANCH || op == `OP_JAL) ? pc : rd1;
        b = (op == `OP_R) ? rd2 : imm;
        addr = (op == `OP_R || op == `OP_I) ? alu_ref(f3, alt, a, b) : a + b;
        cond = branch_ref(f3, rd1, rd2);
        taken = !squash && (op == `OP_JAL || op == `OP_JALR || (op == `OP_BRANCH && cond));
        is_ld = op == `OP_LOAD;
        is_st = op == `OP_STORE;
        en = !squash && (is_ld || is_st) && addr[31:28] == `DMEM_REGION;
        w = addr[13:2];
        din = rd2 << {addr[1:0], 3'b000};
        we = 4'b0000;
        if (en && is_st) begin
            we = (f3[1:0] == 2'd0) ? 4'b0001 << addr[1:0] :
                 (f3[1:0] == 2'd1) ? 4'b0011 << addr[1:0] : 4'b1111;
        end
        cur_dout_valid <= en && is_ld && !$isunknown(shadow[w]);
        cur_dout <= shadow[w];
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                shadow[w][8*i +: 8] = din[8*i +: 8];
            end
        end
        if (!squash && op == `OP_SYSTEM && f3[1:0] == 2'b01 && inst.i_fmt.imm12 == `CSR_TOHOST) begin
            model_tohost = f3[2] ? {27'b0, imm[4:0]} : rd1;
        end
        ex_inst <= inst;
        ex_pc <= pc;
        ex_rd1 <= rd1;
        ex_rd2 <= rd2;
        ex_imm <= imm;
        ex_target_taken <= pred;
        cur_valid <= 1'b1;
        cur_addr <= addr;
        cur_din <= din;
        cur_we <= we;
        cur_taken <= taken;
        cur_flush <= !squash && (op == `OP_JALR || (op == `OP_BRANCH && cond != pred));
        cur_pc4 <= pc + 32'd4;
        cur_redirect <= taken ? addr : pc + 32'd4;
        cur_winst <= squash ? `NOP : inst;
        cur_tohost <= model_tohost;
    endtask

    task automatic issue_nop();
        issue(`NOP, {30'(rand_bits(30)), 2'b00}, rand_bits(32), rand_bits(32), 32'd0, 1'b0);
    endtask

    always @(posedge clk) begin
        started <= 1'b1;
        prev_valid <= cur_valid;
        prev_alu <= cur_addr;
        prev_pc4 <= cur_pc4;
        prev_redirect <= cur_redirect;
        prev_winst <= cur_winst;
        prev_flush <= cur_flush;
        prev_dout_valid <= cur_dout_valid;
        prev_dout <= cur_dout;
        prev_tohost <= cur_tohost;
    end

    assert property (@(posedge clk) cur_valid |-> ex_addr == cur_addr)
        else report_mismatch("ex_addr", $sampled(cur_addr), $sampled(ex_addr));
    assert property (@(posedge clk) cur_valid |-> ex_we == cur_we)
        else report_mismatch("ex_we", $sampled(cur_we), $sampled(ex_we));
    assert property (@(posedge clk) (cur_valid && cur_we != 4'b0) |-> ex_din == cur_din)
        else report_mismatch("ex_din", $sampled(cur_din), $sampled(ex_din));
    assert property (@(posedge clk) cur_valid |-> ex_br_taken == cur_taken)
        else report_mismatch("ex_br_taken", $sampled(cur_taken), $sampled(ex_br_taken));
    assert property (@(posedge clk) cur_valid |-> ex_flush == cur_flush)
        else report_mismatch("ex_flush", $sampled(cur_flush), $sampled(ex_flush));
    assert property (@(posedge clk) prev_valid |-> wb_alu == prev_alu)
        else report_mismatch("wb_alu", $sampled(prev_alu), $sampled(wb_alu));
    assert property (@(posedge clk) prev_valid |-> wb_pc4 == prev_pc4)
        else report_mismatch("wb_pc4", $sampled(prev_pc4), $sampled(wb_pc4));
    assert property (@(posedge clk) prev_valid |-> wb_redirect == prev_redirect)
        else report_mismatch("wb_redirect", $sampled(prev_redirect), $sampled(wb_redirect));
    assert property (@(posedge clk) prev_dout_valid |-> wb_dmem_dout == prev_dout)
        else report_mismatch("wb_dmem_dout", $sampled(prev_dout), $sampled(wb_dmem_dout));
    // These three also hold through reset
    assert property (@(posedge clk) started |-> wb_inst == prev_winst)
        else report_mismatch("wb_inst", $sampled(prev_winst), $sampled(wb_inst));
    assert property (@(posedge clk) started |-> wb_flush == prev_flush)
        else report_mismatch("wb_flush", $sampled(prev_flush), $sampled(wb_flush));
    assert property (@(posedge clk) started |-> tohost == prev_tohost)
        else report_mismatch("tohost", $sampled(prev_tohost), $sampled(tohost));

    initial begin
        int n;
        logic [31:0] base;
        rst = 1'b1;
        ex_pc = '0;
        ex_inst = `NOP;
        ex_rd1 = '0;
        ex_rd2 = '0;
        ex_imm = '0;
        ex_target_taken = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        n = 0;
        while (wb_flush || wb_inst != `NOP) begin
            @(posedge clk);
            n++;
            if (n > 20) timeout_abort("the stage to leave reset");
        end
        repeat (60) begin
            issue(make_inst({1'b0, 1'(rand_bits(1)), 5'b0}, 3'(rand_bits(3)),
                            rand_bits(1) ? `OP_R : `OP_I),
                  {30'(rand_bits(30)), 2'b00}, rand_bits(32), rand_bits(32), rand_bits(32),
                  1'b0);
        end
        foreach (br_f3[i]) begin
            repeat (6) begin
                base = rand_bits(32);
                issue(make_inst(7'd0, br_f3[i], `OP_BRANCH), {30'(rand_bits(30)), 2'b00}, base,
                      rand_bits(1) ? base : rand_bits(32),
                      branch_offset(), 1'(rand_bits(1)));
                issue_nop();
            end
        end
        base = 32'h1000_0000 | {18'd0, 12'(rand_bits(12)), 2'b00};
        issue(make_inst(7'd0, 3'd2, `OP_STORE), 32'h100, base, rand_bits(32), 32'd0, 1'b0);
        issue(make_inst(7'd0, 3'd0, `OP_JAL), 32'h104, 32'd0, 32'd0, 32'd64, 1'b1);
        issue(make_inst(7'd0, 3'd0, `OP_JALR), 32'h108, rand_bits(32), 32'd0, 32'd8, 1'b1);
        // Wrong-path store that must not reach memory
        issue(make_inst(7'd0, 3'd0, `OP_STORE), 32'h10c, base, rand_bits(32), 32'd1, 1'b0);
        issue_nop();
        issue(make_inst(7'd0, 3'd2, `OP_LOAD), 32'h110, base, 32'd0, 32'd0, 1'b0);
        repeat (8) begin
            base = 32'h1000_0000 | {18'd0, 12'(rand_bits(12)), 2'b00};
            issue(make_inst(7'd0, 3'd2, `OP_STORE), 32'h200, base, rand_bits(32), 32'd0, 1'b0);
            issue(make_inst(7'd0, 3'd0, `OP_STORE), 32'h204, base, rand_bits(32),
                  rand_bits(2), 1'b0);
            issue(make_inst(7'd0, 3'd1, `OP_STORE), 32'h208, base, rand_bits(32),
                  {30'd0, 1'(rand_bits(1)), 1'b0}, 1'b0);
            issue(make_inst(7'd0, 3'd2, `OP_STORE), 32'h20c, 32'h2000_0000, rand_bits(32),
                  32'd0, 1'b0);
            issue(make_inst(7'd0, 3'd2, `OP_LOAD), 32'h210, base, 32'd0, 32'd0, 1'b0);
            issue_nop();
        end
        repeat (4) begin
            issue(make_csr(`CSR_TOHOST, 3'b001), 32'h300, rand_bits(32), 32'd0, 32'd0, 1'b0);
            issue(make_csr(`CSR_TOHOST, 3'b101), 32'h304, 32'd0, 32'd0, rand_bits(5), 1'b0);
            issue(make_csr(12'h300, 3'b001), 32'h308, rand_bits(32), 32'd0, 32'd0, 1'b0);
        end
        n = 0;
        while (tohost != model_tohost) begin
            issue_nop();
            n++;
            if (n > 10) timeout_abort("the last tohost write");
        end
        repeat (2) issue_nop();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
ex_pkg.sv
ex_ctrl_if.sv
ex_control.sv
alu_path.sv
data_mem.sv
csr_unit.sv
ex_wb_regs.sv
ex_stage.sv
tb_ex_stage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ex_stage -f flist.f -o sim_ex_stage

output=$(./obj_dir/sim_ex_stage)
echo "$output"

if echo "$output" | grep -q "No errors"; then
    exit 0
else
    exit 1
fi
